/* source/csi2_settings.svh */
`ifndef CSI2_SETTINGS_SVH
`define CSI2_SETTINGS_SVH

// Cycles from reset release to camera power-up
`define CSI2_PWUP_CYCLES 64

// Width of every statistics value
`define CSI2_STAT_W      32

// Register map in byte offsets
`define CSI2_REG_CTRL    8'h00
`define CSI2_REG_HDR_ERR 8'h04
`define CSI2_REG_CRC_ERR 8'h08
`define CSI2_REG_MAX_LN  8'h0C
`define CSI2_REG_MIN_LN  8'h10
`define CSI2_REG_MAX_PX  8'h14
`define CSI2_REG_MIN_PX  8'h18

`endif

/* source/csi2_pkt_pkg.sv */
package csi2_pkt_pkg;

  // Byte 0 arrives first on the link
  typedef struct packed {
    logic             valid;
    logic             sop;
    logic [1:0][7:0]  data;
  } csi2_beat_t;

  typedef enum logic [5:0] {
    DT_FS = 6'h00,
    DT_FE = 6'h01,
    DT_LS = 6'h02,
    DT_LE = 6'h03
  } csi2_dt_e;

  // Data id in the low byte, then word count and ECC in link order
  typedef struct packed {
    logic [7:0]  ecc;
    logic [15:0] wc;
    logic [1:0]  vc;
    logic [5:0]  dt;
  } csi2_hdr_t;

  typedef struct packed {
    logic        tvalid;
    logic        tuser;
    logic        tlast;
    logic [15:0] tdata;
  } video_beat_t;

  typedef struct packed {
    logic hdr_err;
    logic crc_err;
    logic line_end;
    logic frame_end;
  } pkt_evt_t;

  // Parity masks P5 down to P0
  localparam logic [5:0][23:0] ECC_MASK = {
    24'hEFFC00, 24'hDF03F0, 24'hB8E38E,
    24'h749A6D, 24'hF2555B, 24'hF12CB7
  };

  function automatic logic [5:0] ecc6(input logic [23:0] d);
    logic [5:0] p;
    for (int i = 0; i < 6; i++) begin
      p[i] = ^(d & ECC_MASK[i]);
    end
    return p;
  endfunction

endpackage

/* source/csi2_csr_pkg.sv */
`include "csi2_settings.svh"

package csi2_csr_pkg;

  typedef struct packed {
    logic        awvalid;
    logic [7:0]  awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bready;
    logic        arvalid;
    logic [7:0]  araddr;
    logic        rready;
  } axil_req_t;

  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axil_rsp_t;

  typedef struct packed {
    logic phy_en;
    logic clear_stat;
  } csi2_ctrl_t;

  typedef struct packed {
    logic [`CSI2_STAT_W-1:0] hdr_err_cnt;
    logic [`CSI2_STAT_W-1:0] crc_err_cnt;
    logic [`CSI2_STAT_W-1:0] max_ln;
    logic [`CSI2_STAT_W-1:0] min_ln;
    logic [`CSI2_STAT_W-1:0] max_px;
    logic [`CSI2_STAT_W-1:0] min_px;
  } csi2_stat_t;

endpackage

/* source/csi2_pkt_parser.sv */
`timescale 1ns/1ps

module csi2_pkt_parser
  import csi2_pkt_pkg::*;
(
  input  logic        px_clk_i,
  input  logic        rst_n_i,
  input  logic        phy_en_i,
  input  csi2_beat_t  beat_i,
  output video_beat_t video_o,
  output pkt_evt_t    evt_o
);

typedef enum logic [2:0] {
  ST_IDLE,
  ST_HDR,
  ST_PAY,
  ST_CRC,
  ST_DROP
} state_e;

state_e      state;
logic [15:0] hdr_lo;
csi2_hdr_t   hdr;
logic        hdr_ok;
logic        is_long;
logic [15:0] byte_cnt;
logic [15:0] crc;
logic [15:0] crc_next;
logic        fs_pend;
logic        beat_ok;
logic        word_en;
logic        last_word;
logic        vid_tvalid;
logic        vid_tuser;
logic        vid_tlast;
logic [15:0] vid_tdata;

// Reflected CRC-16 with polynomial 0x1021
function automatic logic [15:0] crc16_byte(input logic [15:0] crc_in,
                                           input logic [7:0]  data);
  logic [15:0] c;
  c = crc_in;
  for (int i = 0; i < 8; i++) begin
    if (c[0] ^ data[i]) begin
      c = (c >> 1) ^ 16'h8408;
    end else begin
      c = c >> 1;
    end
  end
  return c;
endfunction

assign beat_ok   = phy_en_i && beat_i.valid;
assign hdr       = {beat_i.data, hdr_lo};
assign hdr_ok    = hdr.ecc == {2'b00, ecc6(hdr[23:0])};
assign is_long   = hdr.dt >= 6'h10;
assign word_en   = beat_ok && !beat_i.sop && (state == ST_PAY);
assign last_word = byte_cnt == 16'd2;
assign crc_next  = crc16_byte(crc16_byte(crc, beat_i.data[0]), beat_i.data[1]);

always_ff @(posedge px_clk_i or negedge rst_n_i) begin
  if (!rst_n_i) begin
    state      <= ST_IDLE;
    fs_pend    <= 1'b0;
    evt_o      <= '0;
    vid_tvalid <= 1'b0;
    vid_tuser  <= 1'b0;
    vid_tlast  <= 1'b0;
  end else begin
    evt_o      <= '0;
    vid_tvalid <= word_en;
    vid_tuser  <= word_en && fs_pend;
    vid_tlast  <= word_en && last_word;
    if (!phy_en_i) begin
      state <= ST_IDLE;
    end else if (beat_i.valid && beat_i.sop) begin
      // A new start abandons whatever was in flight
      state <= ST_HDR;
    end else if (beat_i.valid) begin
      case (state)
        ST_HDR: begin
          if (!hdr_ok) begin
            evt_o.hdr_err <= 1'b1;
            state         <= ST_DROP;
          end else if (is_long) begin
            state <= ST_PAY;
          end else begin
            if (hdr.dt == DT_FS) begin
              fs_pend <= 1'b1;
            end
            evt_o.frame_end <= hdr.dt == DT_FE;
            state           <= ST_IDLE;
          end
        end
        ST_PAY: begin
          fs_pend <= 1'b0;
          if (last_word) begin
            evt_o.line_end <= 1'b1;
            state          <= ST_CRC;
          end
        end
        ST_CRC: begin
          // CRC beat is low byte first
          evt_o.crc_err <= beat_i.data != crc;
          state         <= ST_IDLE;
        end
        default: begin
        end
      endcase
    end
  end
end

always_ff @(posedge px_clk_i) begin
  if (beat_ok && beat_i.sop) begin
    hdr_lo <= beat_i.data;
  end
  if (beat_ok && !beat_i.sop && (state == ST_HDR)) begin
    byte_cnt <= hdr.wc;
    crc      <= 16'hFFFF;
  end
  if (word_en) begin
    byte_cnt  <= byte_cnt - 16'd2;
    crc       <= crc_next;
    vid_tdata <= beat_i.data;
  end
end

assign video_o = '{
  tvalid: vid_tvalid,
  tuser:  vid_tuser,
  tlast:  vid_tlast,
  tdata:  vid_tdata
};

endmodule

/* source/csi2_stat_acc.sv */
`timescale 1ns/1ps
`include "csi2_settings.svh"

module csi2_stat_acc
  import csi2_pkt_pkg::*, csi2_csr_pkg::*;
(
  input  logic        px_clk_i,
  input  logic        rst_n_i,
  input  logic        clear_stat_i,
  input  video_beat_t video_i,
  input  pkt_evt_t    evt_i,
  output csi2_stat_t  stat_o
);

localparam int W = `CSI2_STAT_W;

logic [W-1:0] px_cnt;
logic [W-1:0] ln_cnt;
logic [W-1:0] px_line;
logic [W-1:0] ln_frame;
csi2_stat_t   stat_q;

// Counts including the word or line that closes them
assign px_line  = px_cnt + W'(1);
assign ln_frame = ln_cnt + W'(evt_i.line_end);

always_ff @(posedge px_clk_i or negedge rst_n_i) begin
  if (!rst_n_i) begin
    px_cnt        <= '0;
    ln_cnt        <= '0;
    stat_q        <= '0;
    stat_q.min_ln <= '1;
    stat_q.min_px <= '1;
  end else if (clear_stat_i) begin
    px_cnt        <= '0;
    ln_cnt        <= '0;
    stat_q        <= '0;
    stat_q.min_ln <= '1;
    stat_q.min_px <= '1;
  end else begin
    if (video_i.tvalid) begin
      px_cnt <= video_i.tlast ? '0 : px_line;
    end
    if (evt_i.frame_end) begin
      ln_cnt <= '0;
    end else begin
      ln_cnt <= ln_frame;
    end

    // Saturating error counters
    if (evt_i.hdr_err && (stat_q.hdr_err_cnt != '1)) begin
      stat_q.hdr_err_cnt <= stat_q.hdr_err_cnt + W'(1);
    end
    if (evt_i.crc_err && (stat_q.crc_err_cnt != '1)) begin
      stat_q.crc_err_cnt <= stat_q.crc_err_cnt + W'(1);
    end

    if (evt_i.line_end) begin
      if (px_line > stat_q.max_px) begin
        stat_q.max_px <= px_line;
      end
      if (px_line < stat_q.min_px) begin
        stat_q.min_px <= px_line;
      end
    end

    if (evt_i.frame_end) begin
      if (ln_frame > stat_q.max_ln) begin
        stat_q.max_ln <= ln_frame;
      end
      if (ln_frame < stat_q.min_ln) begin
        stat_q.min_ln <= ln_frame;
      end
    end
  end
end

assign stat_o = stat_q;

endmodule

/* source/csi2_csr.sv */
`timescale 1ns/1ps
`include "csi2_settings.svh"

module csi2_csr
  import csi2_csr_pkg::*;
(
  input  logic       px_clk_i,
  input  logic       rst_n_i,
  input  axil_req_t  req_i,
  output axil_rsp_t  rsp_o,
  output csi2_ctrl_t ctrl_o,
  input  csi2_stat_t stat_i
);

localparam logic [1:0] RESP_OKAY   = 2'b00;
localparam logic [1:0] RESP_SLVERR = 2'b10;

logic        wr_acc;
logic        wr_ctrl;
logic        rd_acc;
logic        bvalid;
logic [1:0]  bresp;
logic        rvalid;
logic [1:0]  rresp;
logic [31:0] rdata;
logic [31:0] rd_mux;
logic        rd_hit;
csi2_ctrl_t  ctrl_q;

assign wr_acc  = req_i.awvalid && req_i.wvalid && !bvalid;
assign wr_ctrl = wr_acc && (req_i.awaddr == `CSI2_REG_CTRL);
assign rd_acc  = req_i.arvalid && !rvalid;

always_comb begin
  rd_hit = 1'b1;
  case (req_i.araddr)
    `CSI2_REG_CTRL:    rd_mux = {31'd0, ctrl_q.phy_en};
    `CSI2_REG_HDR_ERR: rd_mux = 32'(stat_i.hdr_err_cnt);
    `CSI2_REG_CRC_ERR: rd_mux = 32'(stat_i.crc_err_cnt);
    `CSI2_REG_MAX_LN:  rd_mux = 32'(stat_i.max_ln);
    `CSI2_REG_MIN_LN:  rd_mux = 32'(stat_i.min_ln);
    `CSI2_REG_MAX_PX:  rd_mux = 32'(stat_i.max_px);
    `CSI2_REG_MIN_PX:  rd_mux = 32'(stat_i.min_px);
    default: begin
      rd_hit = 1'b0;
      rd_mux = '0;
    end
  endcase
end

always_ff @(posedge px_clk_i or negedge rst_n_i) begin
  if (!rst_n_i) begin
    bvalid <= 1'b0;
    bresp  <= RESP_OKAY;
    rvalid <= 1'b0;
    rresp  <= RESP_OKAY;
    ctrl_q <= '0;
  end else begin
    // Write channel
    if (wr_acc) begin
      bvalid <= 1'b1;
      bresp  <= wr_ctrl ? RESP_OKAY : RESP_SLVERR;
    end else if (req_i.bready) begin
      bvalid <= 1'b0;
    end

    // Clear is a single-cycle strobe
    ctrl_q.clear_stat <= wr_ctrl && req_i.wstrb[0] && req_i.wdata[1];
    if (wr_ctrl && req_i.wstrb[0]) begin
      ctrl_q.phy_en <= req_i.wdata[0];
    end

    // Read channel
    if (rd_acc) begin
      rvalid <= 1'b1;
      rresp  <= rd_hit ? RESP_OKAY : RESP_SLVERR;
    end else if (req_i.rready) begin
      rvalid <= 1'b0;
    end
  end
end

always_ff @(posedge px_clk_i) begin
  if (rd_acc) begin
    rdata <= rd_mux;
  end
end

assign rsp_o = '{
  awready: wr_acc,
  wready:  wr_acc,
  bvalid:  bvalid,
  bresp:   bresp,
  arready: rd_acc,
  rvalid:  rvalid,
  rdata:   rdata,
  rresp:   rresp
};

assign ctrl_o = ctrl_q;

endmodule

/* source/cam_pwup.sv */
`timescale 1ns/1ps
`include "csi2_settings.svh"

module cam_pwup (
  input  logic px_clk_i,
  input  logic rst_n_i,
  output logic cam_pwup_o
);

localparam int CNT_W = $clog2(`CSI2_PWUP_CYCLES);

logic [CNT_W-1:0] cnt;

always_ff @(posedge px_clk_i or negedge rst_n_i) begin
  if (!rst_n_i) begin
    cnt        <= '0;
    cam_pwup_o <= 1'b0;
  end else if (!cam_pwup_o) begin
    cnt <= cnt + CNT_W'(1);
    // Last edge of the delay window
    if (cnt == CNT_W'(`CSI2_PWUP_CYCLES - 1)) begin
      cam_pwup_o <= 1'b1;
    end
  end
end

endmodule

/* source/csi2_rx_wrap.sv */
`timescale 1ns/1ps

module csi2_rx_wrap
  import csi2_pkt_pkg::*, csi2_csr_pkg::*;
(
  input  logic        px_clk_i,
  input  logic        rst_n_i,
  // Lane-merged byte stream
  input  csi2_beat_t  lane_beat_i,
  // Register bus
  input  axil_req_t   csr_req_i,
  output axil_rsp_t   csr_rsp_o,
  // Video out to an always-ready sink
  output video_beat_t video_o,
  output logic        cam_pwup_o
);

video_beat_t video;
pkt_evt_t    evt;
csi2_stat_t  stats;
csi2_ctrl_t  ctrl;

assign video_o = video;

csi2_pkt_parser csi2_pkt_parser_inst (
  .px_clk_i ( px_clk_i    ),
  .rst_n_i  ( rst_n_i     ),
  .phy_en_i ( ctrl.phy_en ),
  .beat_i   ( lane_beat_i ),
  .video_o  ( video       ),
  .evt_o    ( evt         )
);

// Error counts and line geometry
csi2_stat_acc csi2_stat_acc_inst (
  .px_clk_i     ( px_clk_i        ),
  .rst_n_i      ( rst_n_i         ),
  .clear_stat_i ( ctrl.clear_stat ),
  .video_i      ( video           ),
  .evt_i        ( evt             ),
  .stat_o       ( stats           )
);

csi2_csr csi2_csr_inst (
  .px_clk_i ( px_clk_i  ),
  .rst_n_i  ( rst_n_i   ),
  .req_i    ( csr_req_i ),
  .rsp_o    ( csr_rsp_o ),
  .ctrl_o   ( ctrl      ),
  .stat_i   ( stats     )
);

cam_pwup cam_pwup_inst (
  .px_clk_i   ( px_clk_i   ),
  .rst_n_i    ( rst_n_i    ),
  .cam_pwup_o ( cam_pwup_o )
);

endmodule

/* test/tb_csi2_rx_wrap.sv */
`timescale 1ns/1ps
`include "csi2_settings.svh"

module tb_csi2_rx_wrap
  import csi2_pkt_pkg::*, csi2_csr_pkg::*;
();

localparam int TMO  = 50;
localparam int PWUP = `CSI2_PWUP_CYCLES;

// Syndrome column of each header bit from D23 down
localparam logic [23:0][5:0] ECC_COL = {
  6'h3B, 6'h37, 6'h2F, 6'h1F, 6'h38, 6'h34, 6'h32, 6'h31,
  6'h2C, 6'h2A, 6'h29, 6'h26, 6'h25, 6'h23, 6'h1C, 6'h1A,
  6'h19, 6'h16, 6'h15, 6'h13, 6'h0E, 6'h0D, 6'h0B, 6'h07
};

// Index 0 hdr_err up to 5 min_px
localparam logic [5:0][7:0] STAT_OFS = {
  `CSI2_REG_MIN_PX, `CSI2_REG_MAX_PX, `CSI2_REG_MIN_LN,
  `CSI2_REG_MAX_LN, `CSI2_REG_CRC_ERR, `CSI2_REG_HDR_ERR
};

logic        px_clk;
logic        rst_n;
csi2_beat_t  lane_beat;
axil_req_t   csr_req;
axil_rsp_t   csr_rsp;
video_beat_t video;
logic        cam_pwup;
logic [17:0] vid_q [$];
logic [17:0] exp_q [$];
int          check_errs;
int          timeouts;
logic        link_on;
logic        exp_fs;
int          mdl_lines;
logic [31:0] mdl_max_ln;
logic [31:0] mdl_min_ln;
logic [31:0] mdl_max_px;
logic [31:0] mdl_min_px;
logic [31:0] stat_rd [6];
logic [31:0] stat_prev [6];
logic [31:0] rd_data;
logic [1:0]  rd_resp;
logic [1:0]  wr_resp;

csi2_rx_wrap csi2_rx_wrap_inst (
  .px_clk_i    ( px_clk    ),
  .rst_n_i     ( rst_n     ),
  .lane_beat_i ( lane_beat ),
  .csr_req_i   ( csr_req   ),
  .csr_rsp_o   ( csr_rsp   ),
  .video_o     ( video     ),
  .cam_pwup_o  ( cam_pwup  )
);

initial begin
  px_clk = 1'b0;
  forever #50 px_clk = ~px_clk;
end

// {tuser, tlast, tdata} of every video word
always @(negedge px_clk) begin
  if (video.tvalid) begin
    vid_q.push_back({video.tuser, video.tlast, video.tdata});
  end
end

task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) begin
    check_errs++;
    $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
  end
endtask

function automatic logic [5:0] header_parity(input logic [23:0] d);
  logic [5:0] syn;
  syn = '0;
  for (int i = 0; i < 24; i++) begin
    if (d[i]) begin
      syn = syn ^ ECC_COL[i];
    end
  end
  return syn;
endfunction

// Reflected CRC kept as a bit-reversed MSB-first register
function automatic logic [15:0] crc_update(input logic [15:0] crc_in, input logic [7:0] b);
  logic [15:0] r;
  logic [15:0] c;
  logic        fb;
  for (int k = 0; k < 16; k++) begin
    r[k] = crc_in[15-k];
  end
  for (int i = 0; i < 8; i++) begin
    fb = r[15] ^ b[i];
    r  = {r[14:0], 1'b0};
    if (fb) begin
      r = r ^ 16'h1021;
    end
  end
  for (int k = 0; k < 16; k++) begin
    c[k] = r[15-k];
  end
  return c;
endfunction

task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                          output logic [1:0] resp);
  int n;
  resp = 2'b11;
  @(posedge px_clk);
  csr_req.awvalid <= 1'b1;
  csr_req.awaddr  <= addr;
  csr_req.wvalid  <= 1'b1;
  csr_req.wdata   <= data;
  csr_req.wstrb   <= 4'hF;
  csr_req.bready  <= 1'b1;
  n = 0;
  @(negedge px_clk);
  while (!csr_rsp.awready && n < TMO) begin
    @(negedge px_clk);
    n++;
  end
  if (!csr_rsp.awready) begin
    timeouts++;
    $display("Timeout: write to 0x%0h was never accepted", addr);
  end else begin
    check_eq("csr_rsp_o.wready with awready", 32'(csr_rsp.wready), 32'h1);
  end
  @(posedge px_clk);
  csr_req.awvalid <= 1'b0;
  csr_req.wvalid  <= 1'b0;
  n = 0;
  @(negedge px_clk);
  while (!csr_rsp.bvalid && n < TMO) begin
    @(negedge px_clk);
    n++;
  end
  if (!csr_rsp.bvalid) begin
    timeouts++;
    $display("Timeout: no write response for 0x%0h", addr);
  end else begin
    resp = csr_rsp.bresp;
  end
  @(posedge px_clk);
  csr_req.bready <= 1'b0;
endtask

task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                         output logic [1:0] resp);
  int n;
  data = '0;
  resp = 2'b11;
  @(posedge px_clk);
  csr_req.arvalid <= 1'b1;
  csr_req.araddr  <= addr;
  csr_req.rready  <= 1'b1;
  n = 0;
  @(negedge px_clk);
  while (!csr_rsp.arready && n < TMO) begin
    @(negedge px_clk);
    n++;
  end
  if (!csr_rsp.arready) begin
    timeouts++;
    $display("Timeout: read of 0x%0h was never accepted", addr);
  end
  @(posedge px_clk);
  csr_req.arvalid <= 1'b0;
  n = 0;
  @(negedge px_clk);
  while (!csr_rsp.rvalid && n < TMO) begin
    @(negedge px_clk);
    n++;
  end
  if (!csr_rsp.rvalid) begin
    timeouts++;
    $display("Timeout: no read data for 0x%0h", addr);
  end else begin
    data = csr_rsp.rdata;
    resp = csr_rsp.rresp;
  end
  @(posedge px_clk);
  csr_req.rready <= 1'b0;
endtask

task automatic set_ctrl(input logic [31:0] val);
  axil_write(`CSI2_REG_CTRL, val, wr_resp);
  check_eq("bresp of CTRL write", 32'(wr_resp), 32'h0);
  link_on = val[0];
endtask

task automatic read_stats();
  for (int i = 0; i < 6; i++) begin
    axil_read(STAT_OFS[i], stat_rd[i], rd_resp);
    check_eq($sformatf("rresp of 0x%02h", STAT_OFS[i]), 32'(rd_resp), 32'h0);
  end
endtask

task automatic check_cleared();
  read_stats();
  for (int i = 0; i < 6; i++) begin
    check_eq($sformatf("stat reg 0x%02h", STAT_OFS[i]), stat_rd[i],
             (i == 3 || i == 5) ? 32'hFFFF_FFFF : 32'h0);
  end
endtask

task automatic clear_model();
  mdl_lines  = 0;
  mdl_max_ln = '0;
  mdl_min_ln = '1;
  mdl_max_px = '0;
  mdl_min_px = '1;
endtask

task automatic idle_cycles(input int n);
  repeat (n) begin
    @(posedge px_clk);
    lane_beat <= '0;
  end
endtask

// Random idle gap before each valid beat
task automatic drive_beat(input logic sop, input logic [15:0] data);
  int gap;
  gap = int'($urandom % 3);
  idle_cycles(gap);
  @(posedge px_clk);
  lane_beat <= {1'b1, sop, data};
endtask

task automatic send_header(input logic [5:0] dt, input logic [15:0] wc, input int flip);
  logic [31:0] h;
  h[23:0]  = {wc, 2'b00, dt};
  h[31:24] = {2'b00, header_parity(h[23:0])};
  if (flip >= 0) begin
    h[flip] = ~h[flip];
  end
  drive_beat(1'b1, h[15:0]);
  drive_beat(1'b0, h[31:16]);
endtask

task automatic send_short(input logic [5:0] dt, input int flip);
  send_header(dt, 16'($urandom), flip);
  idle_cycles(4);
  if (link_on && flip < 0 && dt == DT_FS) begin
    exp_fs = 1'b1;
  end
  if (link_on && flip < 0 && dt == DT_FE) begin
    if (mdl_lines > mdl_max_ln) begin
      mdl_max_ln = 32'(mdl_lines);
    end
    if (mdl_lines < mdl_min_ln) begin
      mdl_min_ln = 32'(mdl_lines);
    end
    mdl_lines = 0;
  end
endtask

task automatic send_long(input int nwords, input int flip, input logic bad_crc);
  logic [15:0] crc;
  logic [15:0] w;
  logic        good;
  good = link_on && flip < 0;
  send_header(6'h2A, 16'(2 * nwords), flip);
  crc = 16'hFFFF;
  for (int i = 0; i < nwords; i++) begin
    w   = 16'($urandom);
    crc = crc_update(crc_update(crc, w[7:0]), w[15:8]);
    drive_beat(1'b0, w);
    if (good) begin
      exp_q.push_back({exp_fs && (i == 0), i == nwords - 1, w});
    end
  end
  if (bad_crc) begin
    crc ^= 16'h0040;
  end
  drive_beat(1'b0, crc);
  idle_cycles(4);
  if (good) begin
    exp_fs = 1'b0;
    mdl_lines++;
    if (nwords > mdl_max_px) begin
      mdl_max_px = 32'(nwords);
    end
    if (nwords < mdl_min_px) begin
      mdl_min_px = 32'(nwords);
    end
  end
endtask

task automatic expect_video();
  check_eq("video word count", 32'(vid_q.size()), 32'(exp_q.size()));
  for (int i = 0; i < vid_q.size() && i < exp_q.size(); i++) begin
    check_eq($sformatf("video_o word %0d {tuser,tlast,tdata}", i),
             32'(vid_q[i]), 32'(exp_q[i]));
  end
  vid_q.delete();
  exp_q.delete();
endtask

task automatic send_frame(input int nlines);
  send_short(DT_FS, -1);
  repeat (nlines) begin
    send_long(int'(1 + $urandom % 8), -1, 1'b0);
  end
  send_short(DT_FE, -1);
  expect_video();
endtask

task automatic reset_and_power_up();
  int   n;
  logic seen;
  @(negedge px_clk);
  check_eq("video_o {tvalid,tuser,tlast}", {video.tvalid, video.tuser, video.tlast}, 32'h0);
  check_eq("parser events", {28'd0, csi2_rx_wrap_inst.evt}, 32'h0);
  check_eq("csr_rsp_o {awready,wready,arready,bvalid,rvalid}",
           {csr_rsp.awready, csr_rsp.wready, csr_rsp.arready, csr_rsp.bvalid, csr_rsp.rvalid},
           32'h0);
  check_eq("cam_pwup_o", 32'(cam_pwup), 32'h0);
  n    = 0;
  seen = 1'b0;
  while (!seen && n < 4 * PWUP) begin
    @(posedge px_clk);
    n++;
    @(negedge px_clk);
    seen = cam_pwup;
  end
  if (!seen) begin
    timeouts++;
    $display("Timeout: cam_pwup_o never rose");
  end
  check_eq("cam_pwup_o rising edge count", 32'(n), 32'(PWUP));
  check_cleared();
endtask

task automatic stream_good_frame();
  set_ctrl(32'h1);
  axil_read(`CSI2_REG_CTRL, rd_data, rd_resp);
  check_eq("CTRL readback", rd_data, 32'h1);
  send_frame(3);
endtask

task automatic drop_bad_header();
  logic [31:0] hdr0;
  axil_read(`CSI2_REG_HDR_ERR, hdr0, rd_resp);
  send_long(4, int'($urandom % 24), 1'b0);
  expect_video();
  axil_read(`CSI2_REG_HDR_ERR, rd_data, rd_resp);
  check_eq("hdr_err_cnt", rd_data, hdr0 + 32'd1);
  send_long(3, -1, 1'b0);
  expect_video();
endtask

task automatic flag_bad_crc();
  logic [31:0] hdr0;
  logic [31:0] crc0;
  axil_read(`CSI2_REG_HDR_ERR, hdr0, rd_resp);
  axil_read(`CSI2_REG_CRC_ERR, crc0, rd_resp);
  send_long(5, -1, 1'b1);
  expect_video();
  axil_read(`CSI2_REG_CRC_ERR, rd_data, rd_resp);
  check_eq("crc_err_cnt", rd_data, crc0 + 32'd1);
  axil_read(`CSI2_REG_HDR_ERR, rd_data, rd_resp);
  check_eq("hdr_err_cnt", rd_data, hdr0);
endtask

task automatic collect_and_clear_stats();
  set_ctrl(32'h3);
  clear_model();
  axil_read(`CSI2_REG_CTRL, rd_data, rd_resp);
  check_eq("CTRL readback after clear", rd_data, 32'h1);
  send_frame(2);
  send_frame(4);
  read_stats();
  check_eq("hdr_err_cnt", stat_rd[0], 32'h0);
  check_eq("crc_err_cnt", stat_rd[1], 32'h0);
  check_eq("max_ln", stat_rd[2], mdl_max_ln);
  check_eq("min_ln", stat_rd[3], mdl_min_ln);
  check_eq("max_px", stat_rd[4], mdl_max_px);
  check_eq("min_px", stat_rd[5], mdl_min_px);
  set_ctrl(32'h3);
  check_cleared();
endtask

task automatic bus_errors_and_link_off();
  axil_read(8'h40, rd_data, rd_resp);
  check_eq("rresp of unmapped read", 32'(rd_resp), 32'h2);
  check_eq("rdata of unmapped read", rd_data, 32'h0);
  axil_write(`CSI2_REG_HDR_ERR, 32'h1, wr_resp);
  check_eq("bresp of statistics write", 32'(wr_resp), 32'h2);
  set_ctrl(32'h0);
  read_stats();
  stat_prev = stat_rd;
  send_short(DT_FS, -1);
  send_long(4, -1, 1'b0);
  send_long(4, 5, 1'b0);
  send_short(DT_FE, -1);
  expect_video();
  read_stats();
  for (int i = 0; i < 6; i++) begin
    check_eq($sformatf("stat reg 0x%02h with link off", STAT_OFS[i]), stat_rd[i], stat_prev[i]);
  end
  set_ctrl(32'h1);
  @(negedge px_clk);
  check_eq("cam_pwup_o after the tests", 32'(cam_pwup), 32'h1);
endtask

initial begin
  void'($urandom(32'h57eb_9ae0));
  rst_n      = 1'b0;
  lane_beat  = '0;
  csr_req    = '0;
  check_errs = 0;
  timeouts   = 0;
  link_on    = 1'b0;
  exp_fs     = 1'b0;
  clear_model();
  repeat (10) @(posedge px_clk);
  rst_n <= 1'b1;

  reset_and_power_up();
  stream_good_frame();
  drop_bad_header();
  flag_bad_crc();
  collect_and_clear_stats();
  bus_errors_and_link_off();

  $display("Errors: %0d check, %0d timeout", check_errs, timeouts);
  if (check_errs == 0 && timeouts == 0) begin
    $display("Result: PASSED");
  end else begin
    $display("Result: FAILED");
  end
  $finish;
end

endmodule

/* project.f */
+incdir+source
source/csi2_pkt_pkg.sv
source/csi2_csr_pkg.sv
source/csi2_pkt_parser.sv
source/csi2_stat_acc.sv
source/csi2_csr.sv
source/cam_pwup.sv
source/csi2_rx_wrap.sv
test/tb_csi2_rx_wrap.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_csi2_rx_wrap \
  -f project.f --Mdir obj_dir -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "^Result: PASSED$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
